/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -j 0 \
  --top-module tb_slink_ctrl -f verilog.f

out="$(./obj_dir/Vtb_slink_ctrl 2>&1)" || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Test OK$'; then
  exit 0
else
  exit 1
fi

/* slink_apb_decode.sv */
`timescale 1ns/10ps
`include "slink_macros.svh"

module slink_apb_decode (
  input  slink_apb_pkg::apb_addr_t apb_paddr,
  input  logic                     apb_psel,
  input  logic                     apb_penable,
  input  logic                     apb_pwrite,
  input  slink_apb_pkg::apb_data_t apb_pwdata,
  input  slink_apb_pkg::apb_rsp_t  ctrl_rsp,
  output slink_apb_pkg::apb_req_t  ctrl_req,
  output slink_apb_pkg::apb_data_t apb_prdata,
  output logic                     apb_pready,
  output logic                     apb_pslverr
);

  logic                    bist_region;
  slink_apb_pkg::apb_rsp_t bist_rsp;
  slink_apb_pkg::apb_rsp_t sel_rsp;

  // Bit 8 low is the control block, high is BIST
  assign bist_region = apb_paddr[`SLINK_REGION_BIT];

  assign ctrl_req.psel    = apb_psel && !bist_region;
  assign ctrl_req.penable = apb_penable && !bist_region;
  assign ctrl_req.pwrite  = apb_pwrite && !bist_region;
  assign ctrl_req.paddr   = apb_paddr[`SLINK_REG_ADDR_W-1:0];
  assign ctrl_req.pwdata  = apb_pwdata;

  // No BIST behind this region, so every access errors
  assign bist_rsp.prdata  = '0;
  assign bist_rsp.pready  = 1'b1;
  assign bist_rsp.pslverr = apb_psel && apb_penable;

  assign sel_rsp = bist_region ? bist_rsp : ctrl_rsp;

  assign apb_prdata  = sel_rsp.prdata;
  assign apb_pready  = sel_rsp.pready;
  assign apb_pslverr = sel_rsp.pslverr;

endmodule

/* slink_apb_pkg.sv */
`include "slink_macros.svh"

package slink_apb_pkg;

  // Full bus address, including the region bit
  typedef logic [`SLINK_APB_ADDR_W-1:0] apb_addr_t;

  // Offset inside one region
  typedef logic [`SLINK_REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`SLINK_DATA_W-1:0]     apb_data_t;

  // Request towards one region, strobes already qualified
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    reg_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

/* slink_ctrl_pkg.sv */
`include "slink_macros.svh"

package slink_ctrl_pkg;

  // One bit per status / interrupt source
  typedef logic [`SLINK_NUM_IRQ-1:0] irq_vec_t;

  // ---------------------------------------------------------------------------
  // Event sources feeding the status register
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic ecc_corrupted;
    logic ecc_corrected;
    logic crc_corrupted;
    logic in_reset_state;
    logic in_px_state;
    logic wake_seen;
  } link_events_t;

  // ---------------------------------------------------------------------------
  // Software request levels from the PSTATE register
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic p1_enter;
    logic p2_enter;
    logic p3_enter;
    logic link_reset;
    logic link_wake;
  } sw_link_ctrl_t;

endpackage

/* slink_ctrl_regs.sv */
`timescale 1ns/10ps
`include "slink_macros.svh"

module slink_ctrl_regs (
  input  logic                          apb_clk,
  input  logic                          rst_n,
  input  slink_apb_pkg::apb_req_t       req,
  input  slink_ctrl_pkg::link_events_t  events,
  input  logic                          por_reset,
  input  logic                          slink_enable,
  output slink_apb_pkg::apb_rsp_t       rsp,
  output slink_ctrl_pkg::sw_link_ctrl_t sw_ctrl,
  output logic                          main_reset,
  output logic                          link_enable,
  output logic                          interrupt
);

  logic                          swreset_q;
  logic                          enable_q;
  slink_ctrl_pkg::irq_vec_t      status_q;
  slink_ctrl_pkg::irq_vec_t      int_en_q;
  slink_ctrl_pkg::sw_link_ctrl_t pstate_q;

  slink_ctrl_pkg::irq_vec_t      irq_set;
  slink_ctrl_pkg::irq_vec_t      w1c_clr;
  slink_apb_pkg::apb_data_t      rdata;
  logic                          wr_en;
  logic                          addr_hit;

  assign wr_en = req.psel && req.penable && req.pwrite;

  // ---------------------------------------------------------------------------
  // Status sources and W1C
  // ---------------------------------------------------------------------------
  always_comb begin
    irq_set = '0;
    irq_set[`SLINK_IRQ_ECC_CORRUPTED] = events.ecc_corrupted;
    irq_set[`SLINK_IRQ_ECC_CORRECTED] = events.ecc_corrected;
    irq_set[`SLINK_IRQ_CRC_CORRUPTED] = events.crc_corrupted;
    irq_set[`SLINK_IRQ_RESET_SEEN]    = events.in_reset_state;
    irq_set[`SLINK_IRQ_WAKE_SEEN]     = events.wake_seen;
    irq_set[`SLINK_IRQ_IN_PSTATE]     = events.in_px_state;
  end

  assign w1c_clr = (wr_en && req.paddr == `SLINK_REG_STATUS) ?
                   req.pwdata[`SLINK_NUM_IRQ-1:0] : '0;

  // ---------------------------------------------------------------------------
  // Register file
  // ---------------------------------------------------------------------------
  always_ff @(posedge apb_clk or negedge rst_n) begin
    if (!rst_n) begin
      swreset_q <= 1'b0;
      enable_q  <= 1'b0;
      status_q  <= '0;
      int_en_q  <= '0;
      pstate_q  <= '0;
    end else begin
      // A source held high wins over a clear
      status_q <= (status_q & ~w1c_clr) | irq_set;
      if (wr_en) begin
        case (req.paddr)
          `SLINK_REG_MAIN: begin
            swreset_q <= req.pwdata[0];
            enable_q  <= req.pwdata[1];
          end
          `SLINK_REG_INT_EN: begin
            int_en_q <= req.pwdata[`SLINK_NUM_IRQ-1:0];
          end
          `SLINK_REG_PSTATE: begin
            pstate_q.p1_enter   <= req.pwdata[0];
            pstate_q.p2_enter   <= req.pwdata[1];
            pstate_q.p3_enter   <= req.pwdata[2];
            pstate_q.link_reset <= req.pwdata[3];
            pstate_q.link_wake  <= req.pwdata[4];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Read mux
  // ---------------------------------------------------------------------------
  always_comb begin
    rdata    = '0;
    addr_hit = 1'b1;
    case (req.paddr)
      `SLINK_REG_MAIN: begin
        rdata[0] = swreset_q;
        rdata[1] = enable_q;
      end
      `SLINK_REG_STATUS: begin
        rdata[`SLINK_NUM_IRQ-1:0] = status_q;
      end
      `SLINK_REG_INT_EN: begin
        rdata[`SLINK_NUM_IRQ-1:0] = int_en_q;
      end
      `SLINK_REG_PSTATE: begin
        rdata[0] = pstate_q.p1_enter;
        rdata[1] = pstate_q.p2_enter;
        rdata[2] = pstate_q.p3_enter;
        rdata[3] = pstate_q.link_reset;
        rdata[4] = pstate_q.link_wake;
      end
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  assign rsp.prdata  = rdata;
  assign rsp.pready  = 1'b1;
  assign rsp.pslverr = req.psel && req.penable && !addr_hit;

  // Outputs
  assign sw_ctrl     = pstate_q;
  assign main_reset  = por_reset || swreset_q;
  assign link_enable = slink_enable || enable_q;
  assign interrupt   = |(status_q & int_en_q);

endmodule

/* slink_ctrl_top.sv */
`timescale 1ns/10ps

module slink_ctrl_top (
  input  logic                     apb_clk,
  input  logic                     rst_n,
  input  slink_apb_pkg::apb_addr_t apb_paddr,
  input  logic                     apb_pwrite,
  input  logic                     apb_psel,
  input  logic                     apb_penable,
  input  slink_apb_pkg::apb_data_t apb_pwdata,
  output slink_apb_pkg::apb_data_t apb_prdata,
  output logic                     apb_pready,
  output logic                     apb_pslverr,
  input  logic                     por_reset,
  input  logic                     slink_enable,
  input  logic                     ecc_corrupted,
  input  logic                     ecc_corrected,
  input  logic                     crc_corrupted,
  input  logic                     in_reset_state,
  input  logic                     in_px_state,
  input  logic                     tx_sop,
  input  logic                     p1_req,
  input  logic                     p2_req,
  input  logic                     p3_req,
  input  logic                     slink_gpio_wake_n,
  input  logic                     slink_gpio_reset_n,
  output logic                     main_reset,
  output logic                     link_enable,
  output logic                     interrupt,
  output logic                     link_p1_req,
  output logic                     link_p2_req,
  output logic                     link_p3_req,
  output logic                     link_active_req,
  output logic                     link_reset_req
);

  slink_apb_pkg::apb_req_t       ctrl_req;
  slink_apb_pkg::apb_rsp_t       ctrl_rsp;
  slink_ctrl_pkg::link_events_t  events;
  slink_ctrl_pkg::sw_link_ctrl_t sw_ctrl;
  logic                          wake_seen;

  assign events.ecc_corrupted  = ecc_corrupted;
  assign events.ecc_corrected  = ecc_corrected;
  assign events.crc_corrupted  = crc_corrupted;
  assign events.in_reset_state = in_reset_state;
  assign events.in_px_state    = in_px_state;
  assign events.wake_seen      = wake_seen;

  slink_apb_decode u_slink_apb_decode (
    .apb_paddr   ( apb_paddr   ),
    .apb_psel    ( apb_psel    ),
    .apb_penable ( apb_penable ),
    .apb_pwrite  ( apb_pwrite  ),
    .apb_pwdata  ( apb_pwdata  ),
    .ctrl_rsp    ( ctrl_rsp    ),
    .ctrl_req    ( ctrl_req    ),
    .apb_prdata  ( apb_prdata  ),
    .apb_pready  ( apb_pready  ),
    .apb_pslverr ( apb_pslverr ));

  slink_ctrl_regs u_slink_ctrl_regs (
    .apb_clk      ( apb_clk      ),
    .rst_n        ( rst_n        ),
    .req          ( ctrl_req     ),
    .events       ( events       ),
    .por_reset    ( por_reset    ),
    .slink_enable ( slink_enable ),
    .rsp          ( ctrl_rsp     ),
    .sw_ctrl      ( sw_ctrl      ),
    .main_reset   ( main_reset   ),
    .link_enable  ( link_enable  ),
    .interrupt    ( interrupt    ));

  slink_link_req u_slink_link_req (
    .apb_clk            ( apb_clk            ),
    .rst_n              ( rst_n              ),
    .sw_ctrl            ( sw_ctrl            ),
    .tx_sop             ( tx_sop             ),
    .p1_req             ( p1_req             ),
    .p2_req             ( p2_req             ),
    .p3_req             ( p3_req             ),
    .slink_gpio_wake_n  ( slink_gpio_wake_n  ),
    .slink_gpio_reset_n ( slink_gpio_reset_n ),
    .link_p1_req        ( link_p1_req        ),
    .link_p2_req        ( link_p2_req        ),
    .link_p3_req        ( link_p3_req        ),
    .link_active_req    ( link_active_req    ),
    .link_reset_req     ( link_reset_req     ),
    .wake_seen          ( wake_seen          ));

endmodule

/* slink_link_req.sv */
`timescale 1ns/10ps
`include "slink_macros.svh"

module slink_link_req (
  input  logic                          apb_clk,
  input  logic                          rst_n,
  input  slink_ctrl_pkg::sw_link_ctrl_t sw_ctrl,
  input  logic                          tx_sop,
  input  logic                          p1_req,
  input  logic                          p2_req,
  input  logic                          p3_req,
  input  logic                          slink_gpio_wake_n,
  input  logic                          slink_gpio_reset_n,
  output logic                          link_p1_req,
  output logic                          link_p2_req,
  output logic                          link_p3_req,
  output logic                          link_active_req,
  output logic                          link_reset_req,
  output logic                          wake_seen
);

  // Index 0 is wake, index 1 is reset
  logic [1:0][`SLINK_SYNC_STAGES-1:0] sync_q;
  logic [1:0]                         pin_n;
  logic                               gpio_wake;
  logic                               gpio_reset;

  assign pin_n = {slink_gpio_reset_n, slink_gpio_wake_n};

  // ---------------------------------------------------------------------------
  // Sideband synchronizers, idle high
  // ---------------------------------------------------------------------------
  always_ff @(posedge apb_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '1;
    end else begin
      for (int i = 0; i < 2; i++) begin
        sync_q[i] <= {sync_q[i][`SLINK_SYNC_STAGES-2:0], pin_n[i]};
      end
    end
  end

  assign gpio_wake  = !sync_q[0][`SLINK_SYNC_STAGES-1];
  assign gpio_reset = !sync_q[1][`SLINK_SYNC_STAGES-1];

  // Request combining
  assign link_p1_req     = p1_req || sw_ctrl.p1_enter;
  assign link_p2_req     = p2_req || sw_ctrl.p2_enter;
  assign link_p3_req     = p3_req || sw_ctrl.p3_enter;
  assign link_active_req = tx_sop || gpio_wake || sw_ctrl.link_wake;
  assign link_reset_req  = gpio_reset || sw_ctrl.link_reset;

  assign wake_seen = gpio_wake;

endmodule

/* slink_macros.svh */
`ifndef SLINK_MACROS_SVH
`define SLINK_MACROS_SVH

// Bus widths
`define SLINK_APB_ADDR_W        9
`define SLINK_REG_ADDR_W        8
`define SLINK_DATA_W            32
`define SLINK_REGION_BIT        8

`define SLINK_NUM_IRQ           6
`define SLINK_SYNC_STAGES       2

// ---------------------------------------------------------------------------
// Control register offsets
// ---------------------------------------------------------------------------
`define SLINK_REG_MAIN          8'h00
`define SLINK_REG_STATUS        8'h04
`define SLINK_REG_INT_EN        8'h08
`define SLINK_REG_PSTATE        8'h0C

// Status and interrupt enable bit positions
`define SLINK_IRQ_ECC_CORRUPTED 0
`define SLINK_IRQ_ECC_CORRECTED 1
`define SLINK_IRQ_CRC_CORRUPTED 2
`define SLINK_IRQ_RESET_SEEN    3
`define SLINK_IRQ_WAKE_SEEN     4
`define SLINK_IRQ_IN_PSTATE     5

`endif

/* tb_slink_ctrl.sv */
`timescale 1ns/10ps
`include "slink_macros.svh"

module tb_slink_ctrl;

  localparam int N_REG  = 16;
  localparam int N_STAT = 48;
  localparam int N_MIX  = 32;
  // Cycle budget summed over the tests
  localparam int TOTAL_CYCLES = 20 + N_REG * 30 + N_STAT * 8 + N_MIX * 8 + 60;

  typedef struct packed {
    slink_apb_pkg::apb_addr_t paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    slink_apb_pkg::apb_data_t pwdata;
    logic                     por_reset;
    logic                     slink_enable;
    logic [4:0]               evt;
    logic                     tx_sop;
    logic [2:0]               preq;
    logic                     wake_n;
    logic                     reset_n;
  } stim_t;

  typedef struct packed {
    logic       swreset;
    logic       enable;
    logic [5:0] status;
    logic [5:0] int_en;
    logic [4:0] pstate;
    logic [1:0] wake_sync;
    logic [1:0] reset_sync;
  } model_t;

  typedef struct packed {
    logic        main_reset;
    logic        link_enable;
    logic        interrupt;
    logic [2:0]  link_preq;
    logic        link_active_req;
    logic        link_reset_req;
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } resp_t;

  logic        clk = 1'b0;
  logic        rst_n;
  stim_t       din;
  resp_t       dout;
  model_t      model;
  string       test_name = "reset";
  logic [31:0] lfsr = 32'hece0_1b42;

  logic [31:0] prdata;
  logic        pready, pslverr, main_reset, link_enable, interrupt;
  logic        link_p1_req, link_p2_req, link_p3_req, link_active_req, link_reset_req;

  always #4 clk = ~clk;

  slink_ctrl_top dut0 (
    .apb_clk            ( clk              ),
    .rst_n              ( rst_n            ),
    .apb_paddr          ( din.paddr        ),
    .apb_pwrite         ( din.pwrite       ),
    .apb_psel           ( din.psel         ),
    .apb_penable        ( din.penable      ),
    .apb_pwdata         ( din.pwdata       ),
    .apb_prdata         ( prdata           ),
    .apb_pready         ( pready           ),
    .apb_pslverr        ( pslverr          ),
    .por_reset          ( din.por_reset    ),
    .slink_enable       ( din.slink_enable ),
    .ecc_corrupted      ( din.evt[0]       ),
    .ecc_corrected      ( din.evt[1]       ),
    .crc_corrupted      ( din.evt[2]       ),
    .in_reset_state     ( din.evt[3]       ),
    .in_px_state        ( din.evt[4]       ),
    .tx_sop             ( din.tx_sop       ),
    .p1_req             ( din.preq[0]      ),
    .p2_req             ( din.preq[1]      ),
    .p3_req             ( din.preq[2]      ),
    .slink_gpio_wake_n  ( din.wake_n       ),
    .slink_gpio_reset_n ( din.reset_n      ),
    .main_reset         ( main_reset       ),
    .link_enable        ( link_enable      ),
    .interrupt          ( interrupt        ),
    .link_p1_req        ( link_p1_req      ),
    .link_p2_req        ( link_p2_req      ),
    .link_p3_req        ( link_p3_req      ),
    .link_active_req    ( link_active_req  ),
    .link_reset_req     ( link_reset_req   ));

  assign dout = {main_reset, link_enable, interrupt, link_p3_req, link_p2_req, link_p1_req,
                 link_active_req, link_reset_req, pready, pslverr, prdata};

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic model_t reset_model();
    model_t m;
    m            = '0;
    m.wake_sync  = 2'b11;
    m.reset_sync = 2'b11;
    return m;
  endfunction

  function automatic model_t ref_next(model_t s, stim_t d);
    model_t     n;
    logic [5:0] set;
    n   = s;
    // Wake status follows the synced pin, the rest follow the event inputs
    set = {d.evt[4], !s.wake_sync[1], d.evt[3:0]};
    n.status = s.status | set;
    if (d.psel && d.penable && d.pwrite && !d.paddr[8]) begin
      case (d.paddr[7:0])
        `SLINK_REG_MAIN:   {n.enable, n.swreset} = d.pwdata[1:0];
        `SLINK_REG_STATUS: n.status = (s.status & ~d.pwdata[5:0]) | set;
        `SLINK_REG_INT_EN: n.int_en = d.pwdata[5:0];
        `SLINK_REG_PSTATE: n.pstate = d.pwdata[4:0];
        default: ;
      endcase
    end
    n.wake_sync  = {s.wake_sync[0], d.wake_n};
    n.reset_sync = {s.reset_sync[0], d.reset_n};
    return n;
  endfunction

  function automatic resp_t ref_out(model_t s, stim_t d);
    resp_t o;
    logic  hit;
    o.main_reset      = d.por_reset || s.swreset;
    o.link_enable     = d.slink_enable || s.enable;
    o.interrupt       = |(s.status & s.int_en);
    o.link_preq       = d.preq | s.pstate[2:0];
    o.link_active_req = d.tx_sop || !s.wake_sync[1] || s.pstate[4];
    o.link_reset_req  = !s.reset_sync[1] || s.pstate[3];
    o.pready          = 1'b1;
    o.prdata          = '0;
    hit               = 1'b1;
    case (d.paddr[7:0])
      `SLINK_REG_MAIN:   o.prdata[1:0] = {s.enable, s.swreset};
      `SLINK_REG_STATUS: o.prdata[5:0] = s.status;
      `SLINK_REG_INT_EN: o.prdata[5:0] = s.int_en;
      `SLINK_REG_PSTATE: o.prdata[4:0] = s.pstate;
      default:           hit = 1'b0;
    endcase
    // BIST region is empty
    if (d.paddr[8]) begin
      o.prdata = '0;
      hit      = 1'b0;
    end
    o.pslverr = d.psel && d.penable && !hit;
    return o;
  endfunction

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      model = reset_model();
    end
    check({test_name, " outputs"}, 64'(ref_out(model, din)), 64'(dout));
    model = rst_n ? ref_next(model, din) : reset_model();
  end

  initial begin
    #((TOTAL_CYCLES + 200) * 8);
    $display("Simulation timed out after %0d cycles", TOTAL_CYCLES + 200);
    $display("Test FAILED");
    $fatal(1);
  end

  // ---------------------------------------------------------------------------
  // APB and sideband helpers
  // ---------------------------------------------------------------------------
  task automatic apb_xfer(input logic write, input slink_apb_pkg::apb_addr_t addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(posedge clk);
    din.psel   <= 1'b1;
    din.pwrite <= write;
    din.paddr  <= addr;
    din.pwdata <= wdata;
    @(posedge clk);
    din.penable <= 1'b1;
    @(negedge clk);
    rdata = dout.prdata;
    err   = dout.pslverr;
    @(posedge clk);
    din.psel    <= 1'b0;
    din.penable <= 1'b0;
    din.pwrite  <= 1'b0;
  endtask

  task automatic read_expect(input slink_apb_pkg::apb_addr_t addr,
                             input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] data;
    logic        err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check({test_name, " read data"}, 64'(exp_data), 64'(data));
    check({test_name, " pslverr"}, 64'(exp_err), 64'(err));
  endtask

  // Pull one sideband pin low and count edges until its request rises
  task automatic sync_delay(input logic use_reset, output int edges);
    @(posedge clk);
    if (use_reset) begin
      din.reset_n <= 1'b0;
    end else begin
      din.wake_n <= 1'b0;
    end
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!(use_reset ? dout.link_reset_req : dout.link_active_req) && edges < 8);
    @(posedge clk);
    din.wake_n  <= 1'b1;
    din.reset_n <= 1'b1;
    repeat (3) @(posedge clk);
  endtask

  initial begin
    logic [31:0] wd;
    logic [31:0] rd;
    logic [7:0]  off;
    logic        err;
    int          edges;
    rst_n       <= 1'b0;
    din         <= '0;
    din.wake_n  <= 1'b1;
    din.reset_n <= 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    test_name = "register access";
    for (int i = 0; i < N_REG; i++) begin
      wd = rand_bits(32);
      apb_xfer(1'b1, {1'b0, `SLINK_REG_MAIN}, wd, rd, err);
      read_expect({1'b0, `SLINK_REG_MAIN}, {30'd0, wd[1:0]}, 1'b0);
      wd = rand_bits(32);
      apb_xfer(1'b1, {1'b0, `SLINK_REG_INT_EN}, wd, rd, err);
      read_expect({1'b0, `SLINK_REG_INT_EN}, {26'd0, wd[5:0]}, 1'b0);
      wd = rand_bits(32);
      apb_xfer(1'b1, {1'b0, `SLINK_REG_PSTATE}, wd, rd, err);
      read_expect({1'b0, `SLINK_REG_PSTATE}, {27'd0, wd[4:0]}, 1'b0);
      // Offsets from 0x10 up are unmapped
      off = 8'(rand_bits(8)) | 8'h10;
      apb_xfer(1'b1, {1'b0, off}, rand_bits(32), rd, err);
      check({test_name, " unmapped write pslverr"}, 64'd1, 64'(err));
      read_expect({1'b0, off}, 32'd0, 1'b1);
      apb_xfer(1'b1, {1'b1, off}, rand_bits(32), rd, err);
      check({test_name, " bist write pslverr"}, 64'd1, 64'(err));
      read_expect({1'b1, 8'(rand_bits(8))}, 32'd0, 1'b1);
    end

    test_name = "status and interrupt";
    for (int i = 0; i < N_STAT; i++) begin
      @(posedge clk);
      din.evt <= 5'(rand_bits(5) & rand_bits(5));
      apb_xfer(1'b1, {1'b0, `SLINK_REG_STATUS}, rand_bits(32), rd, err);
      if (i % 4 == 0) begin
        apb_xfer(1'b1, {1'b0, `SLINK_REG_INT_EN}, rand_bits(32), rd, err);
      end
    end
    @(posedge clk);
    din.evt <= '0;
    apb_xfer(1'b1, {1'b0, `SLINK_REG_STATUS}, 32'h3f, rd, err);
    read_expect({1'b0, `SLINK_REG_STATUS}, 32'd0, 1'b0);

    test_name = "p-state requests";
    for (int i = 0; i < N_MIX; i++) begin
      @(posedge clk);
      din.preq   <= 3'(rand_bits(3));
      din.tx_sop <= 1'(rand_bits(1));
      apb_xfer(1'b1, {1'b0, `SLINK_REG_PSTATE}, rand_bits(32), rd, err);
    end

    test_name = "sideband pins";
    @(posedge clk);
    din.tx_sop <= 1'b0;
    apb_xfer(1'b1, {1'b0, `SLINK_REG_PSTATE}, 32'd0, rd, err);
    // Wake status drives the interrupt from here on
    apb_xfer(1'b1, {1'b0, `SLINK_REG_INT_EN}, 32'd1 << `SLINK_IRQ_WAKE_SEEN, rd, err);
    sync_delay(1'b0, edges);
    check({test_name, " wake edges"}, 64'd2, 64'(edges));
    sync_delay(1'b1, edges);
    check({test_name, " reset edges"}, 64'd2, 64'(edges));
    read_expect({1'b0, `SLINK_REG_STATUS}, 32'd1 << `SLINK_IRQ_WAKE_SEEN, 1'b0);
    @(posedge clk);
    din.tx_sop <= 1'b1;
    @(negedge clk);
    check({test_name, " tx_sop"}, 64'd1, 64'(dout.link_active_req));
    @(posedge clk);
    din.tx_sop <= 1'b0;
    apb_xfer(1'b1, {1'b0, `SLINK_REG_PSTATE}, 32'h18, rd, err);
    @(negedge clk);
    check({test_name, " sw requests"}, 64'd3, 64'({dout.link_active_req, dout.link_reset_req}));

    test_name = "main reset and enable";
    for (int i = 0; i < N_MIX; i++) begin
      @(posedge clk);
      din.por_reset    <= 1'(rand_bits(1));
      din.slink_enable <= 1'(rand_bits(1));
      apb_xfer(1'b1, {1'b0, `SLINK_REG_MAIN}, rand_bits(32), rd, err);
    end
    @(posedge clk);
    din.por_reset    <= 1'b0;
    din.slink_enable <= 1'b0;
    rst_n            <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
slink_apb_pkg.sv
slink_ctrl_pkg.sv
slink_apb_decode.sv
slink_ctrl_regs.sv
slink_link_req.sv
slink_ctrl_top.sv
tb_slink_ctrl.sv
